//--- peak_pkg.sv
package peak_pkg;

    // the four line sets at the top level fix this count.
    localparam int NUM_CHANNELS = 4;

    // widest sample any receiver can be built for.
    localparam int SAMPLE_BITS_MAX = 16;

    // one ADC sample is right aligned and bits above SAMPLE_BITS stay zero.
    typedef logic [SAMPLE_BITS_MAX-1:0] sample_t;

    // select code for max_value.
    typedef logic [2:0] channel_sel_t;

    localparam channel_sel_t CH_SEL_1 = 3'd1;
    localparam channel_sel_t CH_SEL_2 = 3'd2;
    localparam channel_sel_t CH_SEL_3 = 3'd3;
    localparam channel_sel_t CH_SEL_4 = 3'd4;

    // peaks of one window with channel 1 in slot 0.
    typedef struct packed {
        sample_t [NUM_CHANNELS-1:0] peaks;
        logic    [NUM_CHANNELS-1:0] seen;   // channel got at least one sample.
    } peak_set_t;

    // receiver framing states.
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_SHIFTING,
        RX_DONE
    } rx_state_t;

endpackage

//--- spi_sample_rx.sv
`timescale 1ns/100ps

module spi_sample_rx #(
    parameter int SAMPLE_BITS = 12
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              sclk,
    input  logic              cs_n,
    input  logic              miso,
    output logic              sample_valid,
    output peak_pkg::sample_t sample,
    output logic              frame_error
);

    // one spare code so an overlong frame can never wrap back to a legal count.
    localparam int CNT_BITS = $clog2(peak_pkg::SAMPLE_BITS_MAX + 2);
    localparam logic [CNT_BITS-1:0] CNT_MAX = '1;
    localparam logic [CNT_BITS-1:0] CNT_EXPECT = CNT_BITS'(SAMPLE_BITS);

    logic [1:0] sclk_sync;
    logic [1:0] cs_sync;
    logic [1:0] miso_sync;
    logic       sclk_prev;
    logic       cs_prev;
    logic       sclk_rise;
    logic       cs_fall;
    logic       cs_rise;

    peak_pkg::rx_state_t state;
    logic [CNT_BITS-1:0] bit_count;
    logic                length_ok;
    peak_pkg::sample_t   shift_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_sync <= 2'b00;
            cs_sync   <= 2'b11;   // chip select idles high.
            miso_sync <= 2'b00;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            cs_sync   <= {cs_sync[0], cs_n};
            miso_sync <= {miso_sync[0], miso};
            sclk_prev <= sclk_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign cs_fall   = ~cs_sync[1] & cs_prev;
    assign cs_rise   = cs_sync[1] & ~cs_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= peak_pkg::RX_IDLE;
            bit_count <= '0;
            length_ok <= 1'b0;
        end else begin
            case (state)
                peak_pkg::RX_IDLE: begin
                    if (cs_fall) begin
                        state     <= peak_pkg::RX_SHIFTING;
                        bit_count <= '0;
                    end
                end
                peak_pkg::RX_SHIFTING: begin
                    if (cs_rise) begin
                        state     <= peak_pkg::RX_DONE;
                        length_ok <= (bit_count == CNT_EXPECT);
                    end else if (sclk_rise && bit_count != CNT_MAX) begin
                        bit_count <= bit_count + 1'b1;   // saturates on long frames.
                    end
                end
                default: begin
                    // done is held for one cycle to form the strobes.
                    state     <= cs_fall ? peak_pkg::RX_SHIFTING : peak_pkg::RX_IDLE;
                    bit_count <= '0;
                end
            endcase
        end
    end

    // cleared at frame start so a legal frame leaves the upper bits zero.
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            shift_reg <= '0;
        end else if (state == peak_pkg::RX_SHIFTING && sclk_rise && !cs_rise) begin
            shift_reg <= {shift_reg[peak_pkg::SAMPLE_BITS_MAX-2:0], miso_sync[1]};
        end
    end

    assign sample_valid = (state == peak_pkg::RX_DONE) & length_ok;
    assign frame_error  = (state == peak_pkg::RX_DONE) & ~length_ok;
    assign sample       = shift_reg;

endmodule

//--- peak_tracker.sv
`timescale 1ns/100ps

module peak_tracker (
    input  logic              clk,
    input  logic              reset,
    input  logic              sample_valid,
    input  peak_pkg::sample_t sample,
    input  logic              window_end,
    output peak_pkg::sample_t running_max,
    output logic              seen
);

    logic take_sample;

    // the first sample of a window always wins, even a zero.
    assign take_sample = sample_valid & (~seen | (sample > running_max));

    always_ff @(posedge clk) begin
        if (reset) begin
            seen <= 1'b0;
        end else if (window_end) begin
            seen <= sample_valid;   // a coincident sample opens the new window.
        end else if (take_sample) begin
            seen <= 1'b1;
        end
    end

    // the value only counts while seen is set.
    always_ff @(posedge clk) begin
        if (window_end) begin
            if (sample_valid) begin
                running_max <= sample;
            end
        end else if (take_sample) begin
            running_max <= sample;
        end
    end

endmodule

//--- peak_publisher.sv
`timescale 1ns/100ps

module peak_publisher #(
    parameter int WINDOW_CYCLES = 100000
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  peak_pkg::channel_sel_t                           channel_sel,
    input  peak_pkg::sample_t [peak_pkg::NUM_CHANNELS-1:0]   running_max,
    input  logic [peak_pkg::NUM_CHANNELS-1:0]                seen,
    output logic                                             window_end,
    output logic                                             peak_valid,
    output peak_pkg::peak_set_t                              peak_set,
    output peak_pkg::sample_t                                max_value
);

    localparam int CNT_BITS = $clog2(WINDOW_CYCLES);
    localparam logic [CNT_BITS-1:0] LAST_COUNT = CNT_BITS'(WINDOW_CYCLES - 1);

    logic [CNT_BITS-1:0] window_count;
    peak_pkg::peak_set_t latch_set;

    always_ff @(posedge clk) begin
        if (reset) begin
            window_count <= '0;
        end else if (window_end) begin
            window_count <= '0;
        end else begin
            window_count <= window_count + 1'b1;
        end
    end

    assign window_end = (window_count == LAST_COUNT);

    // unseen channels publish zero whatever their tracker holds.
    always_comb begin
        latch_set.seen = seen;
        for (int ch = 0; ch < peak_pkg::NUM_CHANNELS; ch++) begin
            latch_set.peaks[ch] = seen[ch] ? running_max[ch] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            peak_set   <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= window_end;
            if (window_end) begin
                peak_set <= latch_set;
            end
        end
    end

    always_comb begin
        case (channel_sel)
            peak_pkg::CH_SEL_1: max_value = peak_set.peaks[0];
            peak_pkg::CH_SEL_2: max_value = peak_set.peaks[1];
            peak_pkg::CH_SEL_3: max_value = peak_set.peaks[2];
            peak_pkg::CH_SEL_4: max_value = peak_set.peaks[3];
            default:            max_value = '0;   // codes 0, 5, 6 and 7 read as zero.
        endcase
    end

endmodule

//--- spi_peak_monitor.sv
`timescale 1ns/100ps

module spi_peak_monitor #(
    parameter int SAMPLE_BITS   = 12,
    parameter int WINDOW_CYCLES = 100000
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [peak_pkg::NUM_CHANNELS-1:0] sclk,       // bit 0 is channel 1.
    input  logic [peak_pkg::NUM_CHANNELS-1:0] cs_n,
    input  logic [peak_pkg::NUM_CHANNELS-1:0] miso,
    input  peak_pkg::channel_sel_t            channel_sel,
    output peak_pkg::sample_t                 max_value,
    output peak_pkg::peak_set_t               peak_set,
    output logic                              peak_valid,
    output logic [peak_pkg::NUM_CHANNELS-1:0] frame_error
);

    logic [peak_pkg::NUM_CHANNELS-1:0]              sample_valid;
    peak_pkg::sample_t [peak_pkg::NUM_CHANNELS-1:0] sample;
    peak_pkg::sample_t [peak_pkg::NUM_CHANNELS-1:0] running_max;
    logic [peak_pkg::NUM_CHANNELS-1:0]              seen;
    logic                                           window_end;

    generate
        for (genvar ch = 0; ch < peak_pkg::NUM_CHANNELS; ch++) begin : g_channel
            spi_sample_rx #(
                .SAMPLE_BITS (SAMPLE_BITS)
            ) u_rx (
                .clk          (clk),
                .reset        (reset),
                .sclk         (sclk[ch]),
                .cs_n         (cs_n[ch]),
                .miso         (miso[ch]),
                .sample_valid (sample_valid[ch]),
                .sample       (sample[ch]),
                .frame_error  (frame_error[ch])
            );

            peak_tracker u_tracker (
                .clk          (clk),
                .reset        (reset),
                .sample_valid (sample_valid[ch]),
                .sample       (sample[ch]),
                .window_end   (window_end),
                .running_max  (running_max[ch]),
                .seen         (seen[ch])
            );
        end
    endgenerate

    // one window counter serves all four trackers.
    peak_publisher #(
        .WINDOW_CYCLES (WINDOW_CYCLES)
    ) u_publisher (
        .clk         (clk),
        .reset       (reset),
        .channel_sel (channel_sel),
        .running_max (running_max),
        .seen        (seen),
        .window_end  (window_end),
        .peak_valid  (peak_valid),
        .peak_set    (peak_set),
        .max_value   (max_value)
    );

endmodule

//--- tb_spi_peak_monitor.sv
`timescale 1ns/100ps

module tb_spi_peak_monitor;

    localparam int SAMPLE_BITS   = 12;
    localparam int WINDOW_CYCLES = 2000;
    localparam int NUM_CH        = peak_pkg::NUM_CHANNELS;
    // five aligned tests use two windows each and the rest is slack.
    localparam int MAX_CYCLES    = 25000;

    logic                   clk;
    logic                   reset;
    logic [NUM_CH-1:0]      sclk;
    logic [NUM_CH-1:0]      cs_n;
    logic [NUM_CH-1:0]      miso;
    peak_pkg::channel_sel_t channel_sel;
    peak_pkg::sample_t      max_value;
    peak_pkg::peak_set_t    peak_set;
    logic                   peak_valid;
    logic [NUM_CH-1:0]      frame_error;

    int                value_errors;
    int                other_errors;
    int                cycle_count;
    int                last_valid_cycle;
    logic [31:0]       rng_state;
    peak_pkg::sample_t exp_max [NUM_CH];
    logic [NUM_CH-1:0] exp_seen;
    int                error_pulses [NUM_CH];
    int                pulses_before [NUM_CH];

    spi_peak_monitor #(
        .SAMPLE_BITS   (SAMPLE_BITS),
        .WINDOW_CYCLES (WINDOW_CYCLES)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .miso        (miso),
        .channel_sel (channel_sel),
        .max_value   (max_value),
        .peak_set    (peak_set),
        .peak_valid  (peak_valid),
        .frame_error (frame_error)
    );

    always #5 clk = ~clk;

    // frame_error pulses last one cycle, so they are counted here.
    always @(negedge clk) begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (frame_error[ch] === 1'b1) begin
                error_pulses[ch] = error_pulses[ch] + 1;
            end
        end
    end

    // peak_valid recurs once per window and lasts a single cycle.
    always @(negedge clk) begin
        if (peak_valid === 1'b1) begin
            if (last_valid_cycle >= 0 && cycle_count - last_valid_cycle != WINDOW_CYCLES) begin
                report_mismatch("window_timing", "cycles between peak_valid pulses",
                                WINDOW_CYCLES, cycle_count - last_valid_cycle);
            end
            last_valid_cycle = cycle_count;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Fail %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
        value_errors++;
    endtask

    task automatic report_problem(input string test_name, input string text);
        $display("Error in %s: %s", test_name, text);
        other_errors++;
    endtask

    function automatic void clear_scoreboard();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            exp_max[ch] = '0;
        end
        exp_seen = '0;
    endfunction

    // the first sample of a window always counts as in a tracker.
    function automatic void record_frame(input peak_pkg::sample_t [NUM_CH-1:0] values);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (!exp_seen[ch] || values[ch] > exp_max[ch]) begin
                exp_max[ch] = values[ch];
            end
            exp_seen[ch] = 1'b1;
        end
    endfunction

    function automatic peak_pkg::sample_t expected_peak(input int ch);
        return exp_seen[ch] ? exp_max[ch] : '0;
    endfunction

    // one frame goes out on all channels at once with sclk phases of four clocks each.
    task automatic send_frame(input peak_pkg::sample_t [NUM_CH-1:0] values, input int nbits);
        logic [NUM_CH-1:0] bits;
        @(posedge clk);
        cs_n <= '0;
        repeat (4) @(posedge clk);
        for (int b = nbits - 1; b >= 0; b--) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                bits[ch] = values[ch][b];
            end
            sclk <= '0;
            miso <= bits;   // data settles during the low phase.
            repeat (4) @(posedge clk);
            sclk <= '1;
            repeat (4) @(posedge clk);
        end
        sclk <= '0;
        repeat (4) @(posedge clk);
        cs_n <= '1;
        miso <= '0;
        repeat (6) @(posedge clk);   // the strobe comes three clocks after cs_n rises.
    endtask

    task automatic wait_peak_valid(input string test_name);
        int n;
        n = 0;
        @(negedge clk);
        while (!peak_valid && n < WINDOW_CYCLES + 50) begin
            @(negedge clk);
            n++;
        end
        if (!peak_valid) begin
            report_problem(test_name, "peak_valid did not pulse within one window");
        end
    endtask

    task automatic check_published(input string test_name);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (peak_set.peaks[ch] !== expected_peak(ch)) begin
                report_mismatch(test_name, $sformatf("peak of channel %0d", ch + 1),
                                expected_peak(ch), peak_set.peaks[ch]);
            end
        end
        if (peak_set.seen !== exp_seen) begin
            report_mismatch(test_name, "seen bits", exp_seen, peak_set.seen);
        end
    endtask

    task automatic check_selects(input string test_name);
        peak_pkg::sample_t expected;
        for (int code = 0; code < 8; code++) begin
            @(posedge clk);
            channel_sel <= peak_pkg::channel_sel_t'(code);
            @(negedge clk);
            expected = (code >= 1 && code <= NUM_CH) ? expected_peak(code - 1) : '0;
            if (max_value !== expected) begin
                report_mismatch(test_name, $sformatf("max_value for code %0d", code),
                                expected, max_value);
            end
        end
    endtask

    function automatic void snapshot_error_pulses();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            pulses_before[ch] = error_pulses[ch];
        end
    endfunction

    task automatic check_no_frame_errors(input string test_name);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (error_pulses[ch] != pulses_before[ch]) begin
                report_problem(test_name, $sformatf("unexpected frame_error on channel %0d",
                                                    ch + 1));
            end
        end
    endtask

    // waits until every channel has flagged the last frame.
    task automatic wait_frame_errors(input string test_name);
        int  n;
        logic all_seen;
        n = 0;
        all_seen = 1'b0;
        while (!all_seen && n < 16) begin
            all_seen = 1'b1;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (error_pulses[ch] == pulses_before[ch]) begin
                    all_seen = 1'b0;
                end
            end
            if (!all_seen) begin
                @(negedge clk);
                n++;
            end
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (error_pulses[ch] - pulses_before[ch] != 1) begin
                report_mismatch(test_name, $sformatf("frame_error pulses on channel %0d", ch + 1),
                                1, error_pulses[ch] - pulses_before[ch]);
            end
        end
        snapshot_error_pulses();
    endtask

    task automatic test_after_reset();
        @(negedge clk);
        if (peak_valid !== 1'b0) begin
            report_mismatch("after_reset", "peak_valid", 0, peak_valid);
        end
        if (frame_error !== '0) begin
            report_mismatch("after_reset", "frame_error", 0, frame_error);
        end
        clear_scoreboard();
        check_published("after_reset");
        check_selects("after_reset");
    endtask

    task automatic test_single_frame();
        peak_pkg::sample_t [NUM_CH-1:0] values;
        values = {16'h0C3E, 16'h00FF, 16'h09A5, 16'h0123};
        wait_peak_valid("single_frame");
        clear_scoreboard();
        snapshot_error_pulses();
        send_frame(values, SAMPLE_BITS);
        record_frame(values);
        check_no_frame_errors("single_frame");
        wait_peak_valid("single_frame");
        check_published("single_frame");
        check_selects("single_frame");
    endtask

    task automatic test_several_frames();
        peak_pkg::sample_t [NUM_CH-1:0] values;
        wait_peak_valid("several_frames");
        clear_scoreboard();
        snapshot_error_pulses();
        values = '0;   // a zero frame first must still be beaten by later ones.
        send_frame(values, SAMPLE_BITS);
        record_frame(values);
        for (int f = 0; f < 5; f++) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                rng_state = next_random(rng_state);
                values[ch] = peak_pkg::sample_t'(rng_state & 32'h0000_0FFF);
            end
            send_frame(values, SAMPLE_BITS);
            record_frame(values);
        end
        check_no_frame_errors("several_frames");
        wait_peak_valid("several_frames");
        check_published("several_frames");
    endtask

    task automatic test_empty_window();
        wait_peak_valid("empty_window");
        clear_scoreboard();
        wait_peak_valid("empty_window");
        check_published("empty_window");
    endtask

    task automatic test_bad_lengths();
        peak_pkg::sample_t [NUM_CH-1:0] values;
        values = {16'h1FFF, 16'h0ABC, 16'h0555, 16'h0FFF};
        wait_peak_valid("bad_lengths");
        clear_scoreboard();
        snapshot_error_pulses();
        send_frame(values, SAMPLE_BITS - 1);
        wait_frame_errors("bad_lengths");
        send_frame(values, SAMPLE_BITS + 1);
        wait_frame_errors("bad_lengths");
        wait_peak_valid("bad_lengths");
        check_published("bad_lengths");   // nothing was accepted, so seen stays clear.
    endtask

    task automatic test_invalid_selects();
        peak_pkg::sample_t [NUM_CH-1:0] values;
        values = {16'h03C0, 16'h0FFF, 16'h0042, 16'h07E1};
        wait_peak_valid("invalid_selects");
        clear_scoreboard();
        send_frame(values, SAMPLE_BITS);
        record_frame(values);
        wait_peak_valid("invalid_selects");
        check_published("invalid_selects");
        check_selects("invalid_selects");
    endtask

    initial begin
        clk              = 1'b0;
        value_errors     = 0;
        other_errors     = 0;
        cycle_count      = 0;
        last_valid_cycle = -1;
        rng_state        = 32'd7185;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            error_pulses[ch]  = 0;
            pulses_before[ch] = 0;
        end
        reset       <= 1'b1;
        sclk        <= '0;
        cs_n        <= '1;
        miso        <= '0;
        channel_sel <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        test_after_reset();
        test_single_frame();
        test_several_frames();
        test_empty_window();
        test_bad_lengths();
        test_invalid_selects();

        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
peak_pkg.sv
spi_sample_rx.sv
peak_tracker.sv
peak_publisher.sv
spi_peak_monitor.sv
tb_spi_peak_monitor.sv
